// ==== Bender.yml ====
package:
  name: vga_player

sources:
  - design/vga_player_pkg.sv
  - design/raster_timing.sv
  - design/flash_row_reader.sv
  - design/row_buffer.sv
  - design/pixel_out.sv
  - design/vga_player.sv
  - target: test
    files:
      - testbench/flash_model.sv
      - testbench/tb_vga_player.sv

// ==== design/flash_row_reader.sv ====
`timescale 1ns/1ps

module flash_row_reader (
    input  logic                   px_clk,
    input  logic                   rst,
    input  logic                   cache_empty,
    input  logic                   block_end,
    input  logic                   frame_end,
    input  logic [3:0]             io_in,
    output logic [3:0]             io_out,
    output logic [3:0]             io_oe,
    output logic                   flash_cs_n,
    output logic                   sck_en,
    output logic                   row_done,
    output vga_player_pkg::row_t   row_data
);

    localparam int FRAME_W = $clog2(vga_player_pkg::LAST_FRAME + 1);
    localparam int AW = vga_player_pkg::ADDR_BITS;

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_SEL,
        ST_CMD,
        ST_ADDR,
        ST_DUMMY,
        ST_READ
    } state_e;

    state_e               state;
    logic [5:0]           cnt;
    logic                 start;
    logic                 cs_n_q;
    logic                 first_row;
    logic [AW-1:0]        addr;
    // nibbles 0..30, the last one joins straight from io_in
    logic [vga_player_pkg::ROW_BITS-5:0] shift;

    // position of the row currently on the display
    logic [6:0]           blk;
    logic [1:0]           refresh;
    logic [FRAME_W-1:0]   frame;
    logic [FRAME_W-1:0]   next_frame;
    logic [20:0]          row_idx;
    logic [24:0]          byte_addr;

    // display position, follows the buffer hand-over at block_end
    always_ff @(posedge px_clk) begin
        if (rst) begin
            blk <= '0;
            refresh <= '0;
            frame <= '0;
        end else if (frame_end) begin
            blk <= '0;
            if (refresh == 2'(vga_player_pkg::REFRESH_PER_FRAME - 1)) begin
                refresh <= '0;
                frame <= next_frame;
            end else begin
                refresh <= refresh + 2'd1;
            end
        end else if (block_end) begin
            blk <= blk + 7'd1;
        end
    end

    // row index of the next row to fetch
    always_comb begin
        next_frame = (frame == FRAME_W'(vga_player_pkg::LAST_FRAME))
                   ? '0 : frame + FRAME_W'(1);
        if (first_row) begin
            // very first row after reset is row 0 of frame 0
            row_idx = '0;
        end else if (blk == 7'(vga_player_pkg::BLOCKS_PER_FRAME - 1)) begin
            // last block row, next is row 0 of the coming refresh
            if (refresh == 2'(vga_player_pkg::REFRESH_PER_FRAME - 1)) begin
                row_idx = 21'(next_frame) * 21'(vga_player_pkg::BLOCKS_PER_FRAME);
            end else begin
                row_idx = 21'(frame) * 21'(vga_player_pkg::BLOCKS_PER_FRAME);
            end
        end else begin
            row_idx = 21'(frame) * 21'(vga_player_pkg::BLOCKS_PER_FRAME)
                    + 21'(blk) + 21'd1;
        end
        byte_addr = 25'(row_idx) * 25'(vga_player_pkg::ROW_BYTES);
    end

    assign start = (state == ST_IDLE) && cache_empty;

    // select, 8 command bits, 24 address bits, 8 dummy, 33 read cycles
    always_ff @(posedge px_clk) begin
        if (rst) begin
            state <= ST_IDLE;
            cnt <= '0;
            cs_n_q <= 1'b1;
            first_row <= 1'b1;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (start) begin
                        state <= ST_SEL;
                        cs_n_q <= 1'b0;
                    end
                end
                ST_SEL: begin
                    state <= ST_CMD;
                    cnt <= '0;
                end
                ST_CMD: begin
                    if (cnt == 6'd7) begin
                        state <= ST_ADDR;
                        cnt <= '0;
                    end else begin
                        cnt <= cnt + 6'd1;
                    end
                end
                ST_ADDR: begin
                    if (cnt == 6'(AW - 1)) begin
                        state <= ST_DUMMY;
                        cnt <= '0;
                    end else begin
                        cnt <= cnt + 6'd1;
                    end
                end
                ST_DUMMY: begin
                    if (cnt == 6'(vga_player_pkg::DUMMY_CYCLES - 1)) begin
                        state <= ST_READ;
                        cnt <= '0;
                    end else begin
                        cnt <= cnt + 6'd1;
                    end
                end
                default: begin
                    // read phase, count 0 only launches the first nibble
                    if (row_done) begin
                        state <= ST_IDLE;
                        cnt <= '0;
                        cs_n_q <= 1'b1;
                        first_row <= 1'b0;
                    end else begin
                        cnt <= cnt + 6'd1;
                    end
                end
            endcase
        end
    end

    // address latch and nibble shifter
    always_ff @(posedge px_clk) begin
        if (start) begin
            addr <= byte_addr[AW-1:0];
        end
        if ((state == ST_READ) && (cnt != 6'd0) && !row_done) begin
            shift <= {shift[vga_player_pkg::ROW_BITS-9:0], io_in};
        end
    end

    assign row_done = (state == ST_READ) && (cnt == 6'(vga_player_pkg::NIBBLES_PER_ROW));
    assign row_data = {shift, io_in};

    // command then address go out msb first on io0
    always_comb begin
        io_out = 4'b0000;
        io_oe = 4'b0000;
        if (state == ST_CMD) begin
            io_out[0] = vga_player_pkg::READ_CMD[~cnt[2:0]];
            io_oe[0] = 1'b1;
        end else if (state == ST_ADDR) begin
            io_out[0] = addr[5'(AW - 1) - cnt[4:0]];
            io_oe[0] = 1'b1;
        end
    end

    // clock runs from the first command bit up to the last nibble launch
    assign sck_en = (state == ST_CMD) || (state == ST_ADDR) || (state == ST_DUMMY)
                 || ((state == ST_READ) && !row_done);

    assign flash_cs_n = cs_n_q;

    // a new fetch only begins with the flash deselected
    a_start_deselected : assert property (
        @(posedge px_clk) disable iff (rst) start |-> flash_cs_n
    );

endmodule

// ==== design/pixel_out.sv ====
`timescale 1ns/1ps

module pixel_out (
    input  logic                        px_clk,
    input  logic                        rst,
    input  logic [9:0]                  x_px,
    input  logic                        hsync,
    input  logic                        vsync,
    input  logic                        active,
    input  vga_player_pkg::row_t        disp_row,
    input  vga_player_pkg::pin_layout_e layout,
    input  vga_player_pkg::rgb_t        color_on,
    input  vga_player_pkg::rgb_t        color_off,
    output logic [7:0]                  vga_pins
);

    logic [6:0]           x_blk;
    logic [6:0]           bit_idx;
    logic                 lit;
    vga_player_pkg::rgb_t rgb_q;
    logic                 hsync_q;
    logic                 vsync_q;

    // leftmost block sits in bit 79
    assign x_blk = x_px[9:vga_player_pkg::BLOCK_SHIFT];
    assign bit_idx = 7'(vga_player_pkg::COLS_PER_ROW - 1) - x_blk;

    // index is only meaningful inside the visible area
    assign lit = active ? disp_row[bit_idx] : 1'b0;

    // colour and syncs leave together, one cycle after the raster
    always_ff @(posedge px_clk) begin
        if (rst) begin
            rgb_q <= color_off;
            hsync_q <= 1'b1;
            vsync_q <= 1'b1;
        end else begin
            rgb_q <= lit ? color_on : color_off;
            hsync_q <= hsync;
            vsync_q <= vsync;
        end
    end

    // Tiny VGA: R1 G1 B1 VS R0 G0 B0 HS from pin 0 up
    // clock PMOD: HS VS B0 B1 G0 G1 R0 R1 from pin 0 up
    always_comb begin
        case (layout)
            vga_player_pkg::LAYOUT_CLOCK_PMOD: begin
                vga_pins = {rgb_q[5:0], vsync_q, hsync_q};
            end
            default: begin
                vga_pins = {hsync_q, rgb_q[0], rgb_q[2], rgb_q[4],
                            vsync_q, rgb_q[1], rgb_q[3], rgb_q[5]};
            end
        endcase
    end

endmodule

// ==== design/raster_timing.sv ====
`timescale 1ns/1ps

module raster_timing #(
    parameter int h_total = 832,
    parameter int v_total = 520
) (
    input  logic       px_clk,
    input  logic       rst,
    output logic [9:0] x_px,
    output logic [9:0] y_px,
    output logic       hsync,
    output logic       vsync,
    output logic       active,
    output logic       block_end,
    output logic       frame_end
);

    // sync windows, measured from the first visible column or line
    localparam int HS_START = vga_player_pkg::H_ACTIVE + vga_player_pkg::H_FRONT;
    localparam int HS_END = HS_START + vga_player_pkg::H_SYNC;
    localparam int VS_START = vga_player_pkg::V_ACTIVE + vga_player_pkg::V_FRONT;
    localparam int VS_END = VS_START + vga_player_pkg::V_SYNC;

    logic line_end;

    assign line_end = (x_px == 10'(h_total - 1));

    // column counter wraps at h_total, line counter steps once per line
    always_ff @(posedge px_clk) begin
        if (rst) begin
            x_px <= '0;
            y_px <= '0;
        end else if (line_end) begin
            x_px <= '0;
            if (y_px == 10'(v_total - 1)) begin
                y_px <= '0;
            end else begin
                y_px <= y_px + 10'd1;
            end
        end else begin
            x_px <= x_px + 10'd1;
        end
    end

    // both syncs are active low
    assign hsync = !((x_px >= 10'(HS_START)) && (x_px < 10'(HS_END)));
    assign vsync = !((y_px >= 10'(VS_START)) && (y_px < 10'(VS_END)));

    assign active = (x_px < 10'(vga_player_pkg::H_ACTIVE))
                 && (y_px < 10'(vga_player_pkg::V_ACTIVE));

    // last column of the last line of a block row
    assign block_end = line_end && (&y_px[vga_player_pkg::BLOCK_SHIFT-1:0]);

    // last column of the last line, also a block_end when v_total is a block multiple
    assign frame_end = line_end && (y_px == 10'(v_total - 1));

    // counters stay inside the raster
    a_raster_range : assert property (
        @(posedge px_clk) disable iff (rst)
        (x_px < 10'(h_total)) && (y_px < 10'(v_total))
    );

endmodule

// ==== design/row_buffer.sv ====
`timescale 1ns/1ps

module row_buffer (
    input  logic                 px_clk,
    input  logic                 rst,
    input  logic                 row_done,
    input  vga_player_pkg::row_t row_data,
    input  logic                 block_end,
    output logic                 cache_empty,
    output vga_player_pkg::row_t disp_row
);

    vga_player_pkg::row_t cache_row;
    logic                 cache_full;
    // display stage has been loaded at least once since reset
    logic                 disp_valid;

    // control: cache occupancy and first-row bypass
    always_ff @(posedge px_clk) begin
        if (rst) begin
            cache_full <= 1'b0;
            disp_valid <= 1'b0;
        end else if (row_done) begin
            if (disp_valid) begin
                cache_full <= 1'b1;
            end else begin
                disp_valid <= 1'b1;
            end
        end else if (block_end && cache_full) begin
            cache_full <= 1'b0;
        end
    end

    // cache capture
    always_ff @(posedge px_clk) begin
        if (row_done && disp_valid) begin
            cache_row <= row_data;
        end
    end

    // display stage, held when nothing waits in the cache
    always_ff @(posedge px_clk) begin
        if (rst) begin
            disp_row <= '0;
        end else if (row_done && !disp_valid) begin
            disp_row <= row_data;
        end else if (block_end && cache_full) begin
            disp_row <= cache_row;
        end
    end

    assign cache_empty = !cache_full;

    // reader must wait for the empty level before delivering
    a_no_overrun : assert property (
        @(posedge px_clk) disable iff (rst) row_done |-> !cache_full
    );

endmodule

// ==== design/vga_player.sv ====
`timescale 1ns/1ps

module vga_player #(
    parameter int h_total = vga_player_pkg::H_TOTAL,
    parameter int v_total = vga_player_pkg::V_TOTAL
) (
    input  logic                        px_clk,
    input  logic                        rst,
    input  vga_player_pkg::pin_layout_e layout,
    input  vga_player_pkg::rgb_t        color_on,
    input  vga_player_pkg::rgb_t        color_off,
    input  logic [3:0]                  flash_io_in,
    output logic [7:0]                  vga_pins,
    output logic [3:0]                  flash_io_out,
    output logic [3:0]                  flash_io_oe,
    output logic                        flash_cs_n,
    output logic                        flash_sck
);

    // raster
    logic [9:0] x_px;
    logic       hsync;
    logic       vsync;
    logic       active;
    logic       block_end;
    logic       frame_end;

    // reader to buffer
    logic                 cache_empty;
    logic                 row_done;
    vga_player_pkg::row_t row_data;
    vga_player_pkg::row_t disp_row;
    logic                 sck_en;

    raster_timing #(
        .h_total(h_total),
        .v_total(v_total)
    ) i_raster_timing (
        .px_clk(px_clk),
        .rst(rst),
        .x_px(x_px),
        .y_px(),
        .hsync(hsync),
        .vsync(vsync),
        .active(active),
        .block_end(block_end),
        .frame_end(frame_end)
    );

    flash_row_reader i_flash_row_reader (
        .px_clk(px_clk),
        .rst(rst),
        .cache_empty(cache_empty),
        .block_end(block_end),
        .frame_end(frame_end),
        .io_in(flash_io_in),
        .io_out(flash_io_out),
        .io_oe(flash_io_oe),
        .flash_cs_n(flash_cs_n),
        .sck_en(sck_en),
        .row_done(row_done),
        .row_data(row_data)
    );

    row_buffer i_row_buffer (
        .px_clk(px_clk),
        .rst(rst),
        .row_done(row_done),
        .row_data(row_data),
        .block_end(block_end),
        .cache_empty(cache_empty),
        .disp_row(disp_row)
    );

    pixel_out i_pixel_out (
        .px_clk(px_clk),
        .rst(rst),
        .x_px(x_px),
        .hsync(hsync),
        .vsync(vsync),
        .active(active),
        .disp_row(disp_row),
        .layout(layout),
        .color_on(color_on),
        .color_off(color_off),
        .vga_pins(vga_pins)
    );

    // flash samples on the sck rising edge in the middle of each px_clk cycle
    assign flash_sck = !px_clk && sck_en;

endmodule

// ==== design/vga_player_pkg.sv ====
package vga_player_pkg;

    // raster, 640x480 visible inside an 832x520 total
    localparam int H_ACTIVE = 640;
    localparam int H_TOTAL = 832;
    localparam int H_FRONT = 24;
    localparam int H_SYNC = 40;
    localparam int V_ACTIVE = 480;
    localparam int V_TOTAL = 520;
    localparam int V_FRONT = 9;
    localparam int V_SYNC = 3;
    // back porch is whatever is left of the total

    // one block is 8x8 pixels
    localparam int BLOCK_SHIFT = 3;
    localparam int COLS_PER_ROW = 80;
    // block rows per refresh, blanking rows included
    localparam int BLOCKS_PER_FRAME = 65;

    // flash row layout and the quad output read command
    localparam int ROW_BITS = 128;
    localparam int ROW_BYTES = 16;
    localparam int NIBBLES_PER_ROW = 32;
    localparam logic [7:0] READ_CMD = 8'h6B;
    localparam int ADDR_BITS = 24;
    localparam int DUMMY_CYCLES = 8;

    // each picture is repeated for three refreshes
    localparam int REFRESH_PER_FRAME = 3;
    localparam int LAST_FRAME = 16131;

    typedef logic [ROW_BITS-1:0] row_t;

    // {r1, r0, g1, g0, b1, b0}
    typedef logic [5:0] rgb_t;

    typedef enum logic {
        LAYOUT_TINY_VGA = 1'b0,
        LAYOUT_CLOCK_PMOD = 1'b1
    } pin_layout_e;

endpackage

// ==== filelist.f ====
design/vga_player_pkg.sv
design/raster_timing.sv
design/flash_row_reader.sv
design/row_buffer.sv
design/pixel_out.sv
design/vga_player.sv
testbench/flash_model.sv
testbench/tb_vga_player.sv

// ==== testbench/flash_model.sv ====
`timescale 1ns/1ps

module flash_model (
    input  logic        sck,
    input  logic        cs_n,
    input  logic [3:0]  dq_in,
    input  logic [3:0]  dq_oe,
    output logic [3:0]  dq_out,
    output logic [7:0]  cmd,
    output logic [23:0] addr,
    output logic        oe_bad
);

    // rising sck edges seen since the last deselect
    logic [6:0] bit_cnt;

    // data byte is the low address byte xor a5, high nibble goes out first
    function automatic logic [3:0] nibble_at(input logic [23:0] base, input int n);
        logic [23:0] a;
        logic [7:0]  data;
        a = base + 24'(n >> 1);
        data = a[7:0] ^ 8'hA5;
        return (n % 2 == 0) ? data[7:4] : data[3:0];
    endfunction

    initial begin
        dq_out = 4'h0;
    end

    // 8 command bits, 24 address bits, 8 dummy clocks, then the read clocks
    always @(posedge sck or posedge cs_n) begin
        if (cs_n) begin
            bit_cnt <= '0;
        end else begin
            if (bit_cnt < 7'd8) begin
                cmd <= {cmd[6:0], dq_in[0]};
            end else if (bit_cnt < 7'd32) begin
                addr <= {addr[22:0], dq_in[0]};
            end
            // host drives io0 alone during command and address, nothing after
            if (bit_cnt == 7'd0) begin
                oe_bad <= (dq_oe != 4'b0001);
            end else if ((bit_cnt < 7'd32) && (dq_oe != 4'b0001)) begin
                oe_bad <= 1'b1;
            end else if ((bit_cnt >= 7'd32) && (dq_oe != 4'b0000)) begin
                oe_bad <= 1'b1;
            end
            bit_cnt <= bit_cnt + 7'd1;
        end
    end

    // a nibble leaves on the falling edge after each read clock
    always @(negedge sck) begin
        if (!cs_n && (bit_cnt > 7'd40)) begin
            dq_out <= nibble_at(addr, int'(bit_cnt) - 41);
        end
    end

endmodule

// ==== testbench/tb_vga_player.sv ====
`timescale 1ns/1ps

module tb_vga_player;

    localparam int HS_START = vga_player_pkg::H_ACTIVE + vga_player_pkg::H_FRONT;
    localparam int HS_END = HS_START + vga_player_pkg::H_SYNC;
    localparam int VS_START = vga_player_pkg::V_ACTIVE + vga_player_pkg::V_FRONT;
    localparam int VS_END = VS_START + vga_player_pkg::V_SYNC;
    localparam int WAIT_LIMIT = 2 * vga_player_pkg::H_TOTAL * vga_player_pkg::V_TOTAL;

    logic                        px_clk;
    logic                        rst;
    vga_player_pkg::pin_layout_e layout;
    vga_player_pkg::rgb_t        color_on;
    vga_player_pkg::rgb_t        color_off;
    logic [3:0]                  flash_io_in;
    logic [7:0]                  vga_pins;
    logic [3:0]                  flash_io_out;
    logic [3:0]                  flash_io_oe;
    logic                        flash_cs_n;
    logic                        flash_sck;
    logic [7:0]                  fl_cmd;
    logic [23:0]                 fl_addr;
    logic                        fl_oe_bad;

    // raster position as the testbench expects it and its value one cycle back
    int                   tx;
    int                   ty;
    int                   gref;
    int                   tref;
    int                   tframe;
    int                   p_x;
    int                   p_y;
    int                   p_gref;
    int                   p_ref;
    int                   p_frame;
    vga_player_pkg::rgb_t p_on;
    vga_player_pkg::rgb_t p_off;
    logic                 pv;
    logic                 cs_q;

    logic [31:0] rng;
    logic        timed_out;
    int          pix_errs;
    int          fetch_errs;
    int          misc_errs;
    int          nfetch;
    // address of the block row 0 fetch in each of the first four refreshes
    int          first_addr [4] = '{-1, -1, -1, -1};

    vga_player #(
        .h_total(vga_player_pkg::H_TOTAL),
        .v_total(vga_player_pkg::V_TOTAL)
    ) i_vga_player (
        .px_clk(px_clk),
        .rst(rst),
        .layout(layout),
        .color_on(color_on),
        .color_off(color_off),
        .flash_io_in(flash_io_in),
        .vga_pins(vga_pins),
        .flash_io_out(flash_io_out),
        .flash_io_oe(flash_io_oe),
        .flash_cs_n(flash_cs_n),
        .flash_sck(flash_sck)
    );

    flash_model i_flash_model (
        .sck(flash_sck),
        .cs_n(flash_cs_n),
        .dq_in(flash_io_out),
        .dq_oe(flash_io_oe),
        .dq_out(flash_io_in),
        .cmd(fl_cmd),
        .addr(fl_addr),
        .oe_bad(fl_oe_bad)
    );

    initial begin
        px_clk = 1'b0;
    end

    always #5 px_clk = ~px_clk;

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // block column c is row bit 79-c which is byte 6+c/8 of the row counted msb first
    function automatic vga_player_pkg::rgb_t expected_pixel(
        input int frame,
        input int refresh,
        input int line,
        input int column,
        input vga_player_pkg::rgb_t on,
        input vga_player_pkg::rgb_t off
    );
        int         row;
        int         blk;
        int         byte_addr;
        logic [7:0] data;
        // every refresh of a picture shows the same rows
        if ((line >= vga_player_pkg::V_ACTIVE) || (column >= vga_player_pkg::H_ACTIVE)) begin
            return off;
        end
        row = frame * 65 + (line >> 3);
        blk = column >> 3;
        byte_addr = row * 16 + 6 + blk / 8;
        data = 8'(byte_addr) ^ 8'hA5;
        return data[7 - (blk % 8)] ? on : off;
    endfunction

    // pin orders of the two boards
    // c is {r1, r0, g1, g0, b1, b0}
    function automatic logic [7:0] pack_pins(
        input vga_player_pkg::pin_layout_e lay,
        input vga_player_pkg::rgb_t c,
        input logic hs,
        input logic vs
    );
        logic [7:0] p;
        if (lay == vga_player_pkg::LAYOUT_CLOCK_PMOD) begin
            p = {c[5], c[4], c[3], c[2], c[1], c[0], vs, hs};
        end else begin
            p = {hs, c[0], c[2], c[4], vs, c[1], c[3], c[5]};
        end
        return p;
    endfunction

    // new colours each phase and a flipped layout so both pin orders are seen
    task automatic pick_inputs(input int phase);
        vga_player_pkg::rgb_t on;
        vga_player_pkg::rgb_t off;
        rng = xorshift32(rng);
        on = rng[5:0];
        off = rng[11:6];
        if (off == on) begin
            off = ~on;
        end
        color_on <= on;
        color_off <= off;
        if (phase == 0) begin
            layout <= vga_player_pkg::pin_layout_e'(rng[16]);
        end else if (layout == vga_player_pkg::LAYOUT_TINY_VGA) begin
            layout <= vga_player_pkg::LAYOUT_CLOCK_PMOD;
        end else begin
            layout <= vga_player_pkg::LAYOUT_TINY_VGA;
        end
    endtask

    task automatic wait_raster(input int target_ref, input int target_y, input string what);
        int n;
        n = 0;
        while (!timed_out && !((gref == target_ref) && (ty == target_y) && (tx == 0))) begin
            @(posedge px_clk);
            n++;
            if (n > WAIT_LIMIT) begin
                $display("timeout while waiting for %s", what);
                timed_out = 1'b1;
            end
        end
    endtask

    // raster, refresh and frame tracking
    always @(posedge px_clk) begin
        if (rst) begin
            tx <= 0;
            ty <= 0;
            gref <= 0;
            tref <= 0;
            tframe <= 0;
            pv <= 1'b0;
        end else begin
            p_x <= tx;
            p_y <= ty;
            p_gref <= gref;
            p_ref <= tref;
            p_frame <= tframe;
            p_on <= color_on;
            p_off <= color_off;
            pv <= 1'b1;
            if (tx == vga_player_pkg::H_TOTAL - 1) begin
                tx <= 0;
                if (ty == vga_player_pkg::V_TOTAL - 1) begin
                    ty <= 0;
                    gref <= gref + 1;
                    if (tref == vga_player_pkg::REFRESH_PER_FRAME - 1) begin
                        tref <= 0;
                        tframe <= (tframe == vga_player_pkg::LAST_FRAME) ? 0 : tframe + 1;
                    end else begin
                        tref <= tref + 1;
                    end
                end else begin
                    ty <= ty + 1;
                end
            end else begin
                tx <= tx + 1;
            end
        end
    end

    // pins lag the raster by one cycle and are checked at the falling edge
    always @(negedge px_clk) begin : pixel_check
        logic                 vis;
        logic                 hs;
        logic                 vs;
        vga_player_pkg::rgb_t exp_rgb;
        logic [7:0]           exp_pins;
        if (!rst && pv) begin
            vis = (p_x < vga_player_pkg::H_ACTIVE) && (p_y < vga_player_pkg::V_ACTIVE);
            // all blanking and the visible lines 9, 25, 41 ... of the first two refreshes
            if (!vis || ((p_gref < 2) && (p_y % 16 == 9))) begin
                hs = !((p_x >= HS_START) && (p_x < HS_END));
                vs = !((p_y >= VS_START) && (p_y < VS_END));
                exp_rgb = expected_pixel(p_frame, p_ref, p_y, p_x, p_on, p_off);
                exp_pins = pack_pins(layout, exp_rgb, hs, vs);
                assert (vga_pins == exp_pins) else begin
                    $display("FAIL %0t: pins %h, expected %h at x %0d y %0d refresh %0d",
                             $time, vga_pins, exp_pins, p_x, p_y, p_gref);
                    pix_errs++;
                end
            end
        end
    end

    task automatic check_fetch();
        int          b;
        int          row;
        int          next_f;
        logic [23:0] exp_addr;
        b = ty >> 3;
        next_f = (tframe == vga_player_pkg::LAST_FRAME) ? 0 : tframe + 1;
        if (nfetch == 0) begin
            // first row after reset goes straight to the display
            row = 0;
        end else if (b < vga_player_pkg::BLOCKS_PER_FRAME - 1) begin
            row = tframe * vga_player_pkg::BLOCKS_PER_FRAME + b + 1;
        end else if (tref == vga_player_pkg::REFRESH_PER_FRAME - 1) begin
            row = next_f * vga_player_pkg::BLOCKS_PER_FRAME;
        end else begin
            row = tframe * vga_player_pkg::BLOCKS_PER_FRAME;
        end
        exp_addr = 24'(row * vga_player_pkg::ROW_BYTES);
        assert (fl_cmd == 8'h6B) else begin
            $display("FAIL %0t: fetch %0d command %h, expected 6b", $time, nfetch, fl_cmd);
            fetch_errs++;
        end
        assert (fl_addr == exp_addr) else begin
            $display("FAIL %0t: fetch %0d address %h, expected %h",
                     $time, nfetch, fl_addr, exp_addr);
            fetch_errs++;
        end
        assert (!fl_oe_bad) else begin
            $display("FAIL %0t: fetch %0d io output enable wrong", $time, nfetch);
            fetch_errs++;
        end
        if ((nfetch > 0) && (b == 0) && (gref < 4)) begin
            first_addr[gref] = int'(fl_addr);
        end
        nfetch++;
    endtask

    // a fetch is over when cs goes back high
    always @(negedge px_clk) begin
        if (rst) begin
            cs_q <= 1'b1;
        end else begin
            cs_q <= flash_cs_n;
            if ((cs_q == 1'b0) && (flash_cs_n == 1'b1)) begin
                check_fetch();
            end
        end
    end

    initial begin
        rng = 32'd20;
        timed_out = 1'b0;
        pix_errs = 0;
        fetch_errs = 0;
        misc_errs = 0;
        nfetch = 0;
        rst = 1'b1;
        layout = vga_player_pkg::LAYOUT_TINY_VGA;
        color_on = '0;
        color_off = '0;
        pick_inputs(0);

        // reset for 10 cycles with the outputs checked in the last one
        repeat (9) @(posedge px_clk);
        @(negedge px_clk);
        assert ((flash_cs_n == 1'b1) && (flash_io_oe == 4'b0000)) else begin
            $display("FAIL %0t: flash cs %b oe %b during reset", $time, flash_cs_n, flash_io_oe);
            misc_errs++;
        end
        assert (vga_pins == pack_pins(layout, color_off, 1'b1, 1'b1)) else begin
            $display("FAIL %0t: pins %h during reset", $time, vga_pins);
            misc_errs++;
        end
        @(posedge px_clk);
        rst <= 1'b0;

        // new colours and layout at the start of each vertical blanking
        for (int ph = 1; ph < 4; ph++) begin
            wait_raster(ph - 1, vga_player_pkg::V_ACTIVE, "vertical blanking");
            pick_inputs(ph);
        end
        wait_raster(3, 24, "block row 3 of the fourth refresh");

        if (!timed_out) begin
            assert ((first_addr[1] == first_addr[0]) && (first_addr[2] == first_addr[0]))
            else begin
                $display("FAIL %0t: row 0 fetches %0d %0d %0d differ within one picture",
                         $time, first_addr[0], first_addr[1], first_addr[2]);
                misc_errs++;
            end
            assert (first_addr[3] - first_addr[0] == 65 * 16) else begin
                $display("FAIL %0t: next picture starts at %0d, previous at %0d",
                         $time, first_addr[3], first_addr[0]);
                misc_errs++;
            end
            assert (nfetch >= 3 * vga_player_pkg::BLOCKS_PER_FRAME) else begin
                $display("FAIL %0t: only %0d row fetches, expected at least %0d",
                         $time, nfetch, 3 * vga_player_pkg::BLOCKS_PER_FRAME);
                misc_errs++;
            end
        end

        $display("errors: pixel %0d, fetch %0d, other %0d", pix_errs, fetch_errs, misc_errs);
        if (!timed_out && (pix_errs + fetch_errs + misc_errs == 0)) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule
